// File: compile.f
verilog/spidergon_pkg.sv
verilog/rr_arbiter.sv
verilog/vc_fifo.sv
verilog/vc_reservation_table.sv
verilog/input_port.sv
verilog/output_switch.sv
verilog/spidergon_node.sv
verification/spidergon_node_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and fail on a bad status or a failing log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module spidergon_node_tb -o spidergon_sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi
./obj_dir/spidergon_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0

// File: verification/spidergon_node_tb.sv
// node 0 with depth 4; the top three head payload bits carry the source lane tag
`timescale 1ns/10ps
module spidergon_node_tb
	import spidergon_pkg::*;
();
	localparam int NODE_ID = 0;
	localparam int DEPTH = 4;
	localparam int NLANE = NUM_LINKS * NUM_VC;  // input vcs with one packet stream each
	localparam int NOUT = NUM_LINKS + 1;        // neighbours plus eject
	localparam int EJECT_KEY = NLANE;           // eject's slot in bound[]
	localparam int PKTS_PER_LANE = 40;

	logic                 clk;
	logic                 reset;
	flit_t                in_flit [NUM_LINKS];
	logic [NUM_LINKS-1:0] in_valid;
	logic [NUM_VC-1:0]    in_credit [NUM_LINKS];
	flit_t                out_flit [NUM_LINKS];
	logic [NUM_LINKS-1:0] out_valid;
	logic [NUM_VC-1:0]    out_credit [NUM_LINKS];
	flit_t                eject_flit;
	logic                 eject_valid;

	logic [31:0] lcg_state;
	flit_t pend_q [NLANE][$];       // flits still to send per input vc
	flit_t exp_q [NOUT*NLANE][$];   // model queues per output and source lane
	int    lane_route [NLANE];      // output of the packet being sent
	int    pkts_built [NLANE];
	int    up_credit [NLANE];       // credits held for the DUT's input vcs
	int    sent_cnt [NLANE];
	int    ret_cnt [NLANE];
	int    held [NLANE];            // flits sitting downstream per output vc
	int    bound [NLANE+1];         // lane owning an output vc or eject or -1 when free
	int    eject_vc;                // vc field of the packet holding eject
	int    withhold_port;
	int    withhold_left;           // cycles of credit withholding left
	int    flits_sent;
	int    pkts_sent;
	int    pkts_done;
	int    errors;

	spidergon_node #(
		.NODE_ID(NODE_ID),
		.BUFFER_DEPTH(DEPTH)
	) DUT (
		.clk(clk),
		.reset(reset),
		.in_flit(in_flit),
		.in_valid(in_valid),
		.in_credit(in_credit),
		.out_flit(out_flit),
		.out_valid(out_valid),
		.out_credit(out_credit),
		.eject_flit(eject_flit),
		.eject_valid(eject_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// lcg step returning 0 .. n-1
	function automatic int next_rand(input int n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % n;
	endfunction

	// spidergon shortest path from NODE_ID giving 0 acw 1 cw 2 across 3 eject
	function automatic int expected_port(input int dest);
		int rel;
		rel = (dest - NODE_ID + NUM_NODES) % NUM_NODES;
		if (rel == 0)
			return 3;
		if (rel <= NUM_NODES / 4)
			return 1;
		if (rel >= 3 * NUM_NODES / 4)
			return 0;
		return 2;
	endfunction

	task automatic flag_error(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		errors++;
	endtask

	// random single-flit or head + 1..4 body + tail packet
	task automatic build_packet(input int lane);
		flit_t f;
		int    nbody;
		int    hi;
		int    lo;
		f = '0;
		f.head.kind = (next_rand(2) == 0) ? FLIT_SINGLE : FLIT_HEAD;
		f.head.vc = VC_W'(lane % NUM_VC);  // selects the DUT input fifo
		f.head.dest = NODE_W'(next_rand(NUM_NODES));
		f.head.src = NODE_W'(next_rand(NUM_NODES));
		lo = next_rand(128);
		f.head.payload = {3'(lane), 7'(lo)};  // lane tag so the checker finds the stream
		pend_q[lane].push_back(f);
		if (f.head.kind == FLIT_HEAD)
		begin
			nbody = 1 + next_rand(4);
			for (int i = 0; i <= nbody; i++)
			begin
				hi = next_rand(256);
				lo = next_rand(256);
				f.body.kind = (i == nbody) ? FLIT_TAIL : FLIT_BODY;
				f.body.payload = DATA_W'(hi * 256 + lo);
				pend_q[lane].push_back(f);
			end
		end
		pkts_built[lane]++;
	endtask

	task automatic send_flit(input int p, input int lane);
		flit_t f;
		f = pend_q[lane].pop_front();
		if (f.head.kind == FLIT_HEAD || f.head.kind == FLIT_SINGLE)
		begin
			lane_route[lane] = expected_port(int'(f.head.dest));
			pkts_sent++;
		end
		exp_q[lane_route[lane] * NLANE + lane].push_back(f);
		in_flit[p] = f;
		in_valid[p] = 1'b1;
		up_credit[lane]--;
		sent_cnt[lane]++;
		flits_sent++;
	endtask

	// at most one flit per link with random vc order so packets interleave
	task automatic drive_inputs();
		int lane;
		int pick;
		int start;
		for (int p = 0; p < NUM_LINKS; p++)
		begin
			in_valid[p] = 1'b0;
			in_flit[p] = '0;
			pick = -1;
			start = next_rand(NUM_VC);
			for (int k = 0; k < NUM_VC; k++)
			begin
				lane = p * NUM_VC + (start + k) % NUM_VC;
				if (pend_q[lane].size() == 0 && pkts_built[lane] < PKTS_PER_LANE)
					build_packet(lane);
				if (pick < 0 && pend_q[lane].size() > 0 && up_credit[lane] > 0)
					pick = lane;
			end
			if (pick >= 0 && next_rand(4) != 0)  // idle now and then
				send_flit(p, pick);
		end
	endtask

	function automatic bit stim_done();
		for (int l = 0; l < NLANE; l++)
			if (pkts_built[l] < PKTS_PER_LANE || pend_q[l].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic bit all_done();
		if (!stim_done())
			return 1'b0;
		for (int l = 0; l < NLANE; l++)
			if (up_credit[l] != DEPTH)
				return 1'b0;  // flits still inside the DUT
		for (int q = 0; q < NOUT * NLANE; q++)
			if (exp_q[q].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	// downstream neighbours return credits at random and stall one output for long stretches
	task automatic drive_credits();
		bit stalled;
		if (withhold_left > 0)
			withhold_left--;
		else if (!stim_done() && next_rand(150) == 0)
		begin
			withhold_port = next_rand(NUM_LINKS);
			withhold_left = 100 + next_rand(300);
		end
		for (int o = 0; o < NUM_LINKS; o++)
		begin
			stalled = (withhold_left > 0) && (withhold_port == o);
			for (int d = 0; d < NUM_VC; d++)
			begin
				out_credit[o][d] = 1'b0;
				if (held[o * NUM_VC + d] > 0 && !stalled && next_rand(3) == 0)
				begin
					out_credit[o][d] = 1'b1;
					held[o * NUM_VC + d]--;
				end
			end
		end
	endtask

	// o == NUM_LINKS means eject
	task automatic check_output(input int o, input flit_t f);
		int    key;
		int    lane;
		int    qi;
		flit_t e;
		key = (o == NUM_LINKS) ? EJECT_KEY : o * NUM_VC + int'(f.body.vc);
		if (o < NUM_LINKS)
		begin
			if (held[key] >= DEPTH)
				flag_error($sformatf("output %0d vc %0d sent with no credit left%s", o,
					f.body.vc, (withhold_left > 0 && withhold_port == o) ? " while withheld" : ""));
			held[key]++;
		end
		if (f.head.kind == FLIT_HEAD || f.head.kind == FLIT_SINGLE)
		begin
			if (o < NUM_LINKS && int'(f.head.dest) == NODE_ID)
				flag_error($sformatf("head for this node left on output %0d", o));
			if (bound[key] >= 0)
				flag_error($sformatf("head on output %0d vc %0d cuts into another packet",
					o, f.body.vc));
			lane = int'(f.head.payload[HEAD_PAYLOAD_W-1 -: 3]);
		end
		else
		begin
			lane = bound[key];
			if (lane < 0)
			begin
				flag_error($sformatf("body or tail on output %0d vc %0d with no open packet",
					o, f.body.vc));
				return;
			end
		end
		if (lane >= NLANE)
		begin
			flag_error($sformatf("head on output %0d carries a bad lane tag %0d", o, lane));
			return;
		end
		qi = o * NLANE + lane;
		if (exp_q[qi].size() == 0)
		begin
			flag_error($sformatf("output %0d got a flit from input vc %0d that goes elsewhere",
				o, lane));
			return;
		end
		e = exp_q[qi].pop_front();
		if (e.body.kind != f.body.kind || e.body.payload != f.body.payload)
			flag_error($sformatf("output %0d lane %0d: got kind %0d data %h, expected kind %0d data %h",
				o, lane, f.body.kind, f.body.payload, e.body.kind, e.body.payload));
		if (o == NUM_LINKS)
		begin
			if (f.head.kind == FLIT_HEAD)
				eject_vc = int'(f.body.vc);
			else if (f.head.kind != FLIT_SINGLE && int'(f.body.vc) != eject_vc)
				flag_error($sformatf("eject lane %0d: vc %0d inside a packet begun on vc %0d",
					lane, f.body.vc, eject_vc));
		end
		if (f.head.kind == FLIT_HEAD)
			bound[key] = lane;  // downstream vc now owned until the tail
		else if (f.head.kind == FLIT_TAIL)
			bound[key] = -1;
		if (f.head.kind == FLIT_SINGLE || f.head.kind == FLIT_TAIL)
			pkts_done++;
	endtask

	// outputs and credit pulses are stable at the falling edge
	task automatic sample_outputs();
		int lane;
		for (int o = 0; o < NUM_LINKS; o++)
			if (out_valid[o])
				check_output(o, out_flit[o]);
		if (eject_valid)
			check_output(NUM_LINKS, eject_flit);
		for (int p = 0; p < NUM_LINKS; p++)
			for (int v = 0; v < NUM_VC; v++)
				if (in_credit[p][v])
				begin
					lane = p * NUM_VC + v;
					up_credit[lane]++;
					ret_cnt[lane]++;
					if (ret_cnt[lane] > sent_cnt[lane])
						flag_error($sformatf("extra credit on link %0d vc %0d", p, v));
				end
	endtask

	task automatic check_idle();
		if (out_valid != '0 || eject_valid)
			flag_error("output valid high during or just after reset");
		for (int p = 0; p < NUM_LINKS; p++)
			if (in_credit[p] != '0)
				flag_error($sformatf("credit pulse on link %0d during or just after reset", p));
	endtask

	initial
	begin
		lcg_state = 32'd17;
		reset = 1'b1;
		in_valid = '0;
		eject_vc = 0;
		withhold_port = 0;
		withhold_left = 0;
		flits_sent = 0;
		pkts_sent = 0;
		pkts_done = 0;
		errors = 0;
		for (int p = 0; p < NUM_LINKS; p++)
		begin
			in_flit[p] = '0;
			out_credit[p] = '0;
		end
		for (int l = 0; l < NLANE; l++)
		begin
			lane_route[l] = 0;
			pkts_built[l] = 0;
			up_credit[l] = DEPTH;
			sent_cnt[l] = 0;
			ret_cnt[l] = 0;
			held[l] = 0;
		end
		for (int k = 0; k <= NLANE; k++)
			bound[k] = -1;
		for (int c = 0; c < 4; c++)  // reset spans four rising edges
		begin
			@(negedge clk);
			check_idle();
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle();  // first cycle out of reset
		do
		begin
			drive_credits();
			drive_inputs();
			@(negedge clk);
			sample_outputs();
		end
		while (!all_done());
		in_valid = '0;
		repeat (20)  // drain where nothing more may show up
		begin
			drive_credits();
			@(negedge clk);
			sample_outputs();
		end
		for (int l = 0; l < NLANE; l++)
			if (ret_cnt[l] != sent_cnt[l])
				flag_error($sformatf("input vc %0d: %0d credits back for %0d flits", l,
					ret_cnt[l], sent_cnt[l]));
		if (pkts_done != pkts_sent)
			flag_error($sformatf("%0d packets delivered of %0d sent", pkts_done, pkts_sent));
		$display("errors: %0d, packets sent: %0d, delivered: %0d, flits sent: %0d",
			errors, pkts_sent, pkts_done, flits_sent);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// limit of 40 cycles per flit sent plus 1000 grows with traffic
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 40 * flits_sent + 1000)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d of %0d packets delivered, %0d errors",
			cycles, pkts_done, pkts_sent, errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: verilog/input_port.sv
// dequeues only on the switch's deq pulse; flits must carry a valid vc and arrive within credits
`timescale 1ns/10ps
module input_port
	import spidergon_pkg::*;
#(
	parameter int NODE_ID      = 0,
	parameter int BUFFER_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  flit_t             in_flit,
	input  logic              in_valid,
	output logic [NUM_VC-1:0] in_credit,
	output flit_t             head_flit [NUM_VC],
	output logic [NUM_VC-1:0] vc_ready,
	output logic [PORT_W-1:0] vc_route [NUM_VC],
	output logic [NUM_VC-1:0] vc_needs_alloc,
	input  logic [NUM_VC-1:0] deq,
	input  logic [VC_W-1:0]   alloc_vc [NUM_VC]
);
	flit_t             fifo_flit [NUM_VC];     // front of each fifo
	logic [NUM_VC-1:0] fifo_empty;
	logic [PORT_W-1:0] calc_route [NUM_VC];    // route from the front flit's dest
	logic [NUM_VC-1:0] is_head;                // front flit opens a packet
	logic [NUM_VC-1:0] reserve;
	logic [NUM_VC-1:0] release_en;
	logic [NUM_VC-1:0] busy;
	logic [PORT_W-1:0] locked_route [NUM_VC];
	logic [VC_W-1:0]   down_vc [NUM_VC];

	// spidergon shortest path on rel = dest - NODE_ID
	function automatic logic [PORT_W-1:0] route_of(input logic [NODE_W-1:0] dest);
		logic [NODE_W-1:0] rel;
		rel = dest - NODE_W'(NODE_ID);  // wraps mod NUM_NODES
		if (rel == '0)
			return PORT_LOCAL;
		else if (rel <= NODE_W'(NUM_NODES / 4))
			return PORT_CLOCKWISE;
		else if (rel >= NODE_W'(3 * NUM_NODES / 4))
			return PORT_ANTICLOCKWISE;
		else
			return PORT_ACROSS;  // middle of the ring
	endfunction

	genvar v;
	generate
		for (v = 0; v < NUM_VC; v++)
		begin : g_vc
			// flit's vc field selects the fifo
			vc_fifo #(.DEPTH(BUFFER_DEPTH)) u_fifo (
				.clk(clk),
				.reset(reset),
				.wr_en(in_valid && (in_flit.body.vc == VC_W'(v))),
				.wr_flit(in_flit),
				.rd_en(deq[v]),
				.rd_flit(fifo_flit[v]),
				.empty(fifo_empty[v])
			);

			assign is_head[v] = (fifo_flit[v].head.kind == FLIT_HEAD) ||
				(fifo_flit[v].head.kind == FLIT_SINGLE);
			assign calc_route[v] = route_of(fifo_flit[v].head.dest);

			assign vc_ready[v] = !fifo_empty[v];
			assign vc_needs_alloc[v] = vc_ready[v] && !busy[v] && is_head[v];  // no owner yet
			assign vc_route[v] = busy[v] ? locked_route[v] : calc_route[v];

			// table update on the dequeue itself
			assign reserve[v] = deq[v] && !busy[v] && (fifo_flit[v].head.kind == FLIT_HEAD);
			assign release_en[v] = deq[v] && busy[v] && (fifo_flit[v].head.kind == FLIT_TAIL);

			assign in_credit[v] = deq[v];  // one credit back per flit leaving the fifo

			// owned packets go out on their downstream vc, new heads get theirs in the switch
			assign head_flit[v] = busy[v] ?
				{fifo_flit[v].body.kind, down_vc[v], fifo_flit[v].body.payload} : fifo_flit[v];
		end
	endgenerate

	vc_reservation_table u_table (
		.clk(clk),
		.reset(reset),
		.reserve(reserve),
		.release_en(release_en),
		.new_route(calc_route),
		.new_vc(alloc_vc),     // vc allocated with this head
		.busy(busy),
		.route(locked_route),
		.down_vc(down_vc)
	);

endmodule

// File: verilog/output_switch.sv
// one flit per output per cycle; eject has no back-pressure so the CPU must sink every flit
`timescale 1ns/10ps
module output_switch
	import spidergon_pkg::*;
#(
	parameter int BUFFER_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  flit_t                head_flit [NUM_LINKS][NUM_VC],
	input  logic [NUM_VC-1:0]    vc_ready [NUM_LINKS],
	input  logic [PORT_W-1:0]    vc_route [NUM_LINKS][NUM_VC],
	input  logic [NUM_VC-1:0]    vc_needs_alloc [NUM_LINKS],
	output logic [NUM_VC-1:0]    deq [NUM_LINKS],
	output logic [VC_W-1:0]      alloc_vc [NUM_LINKS][NUM_VC],
	output flit_t                out_flit [NUM_LINKS],
	output logic [NUM_LINKS-1:0] out_valid,
	input  logic [NUM_VC-1:0]    out_credit [NUM_LINKS],
	output flit_t                eject_flit,
	output logic                 eject_valid
);
	localparam int NREQ = NUM_LINKS * NUM_VC;  // every input vc can request
	localparam int NOUT = NUM_LINKS + 1;       // neighbours plus eject
	localparam int CW   = $clog2(BUFFER_DEPTH + 1);

	logic [CW-1:0]     credit [NUM_LINKS][NUM_VC];  // free slots at each downstream vc
	logic [NUM_VC-1:0] dvc_busy [NUM_LINKS];        // downstream vc owned by a packet
	logic              eject_lock;                  // eject port held head to tail

	logic [NUM_LINKS-1:0] free_any;     // some downstream vc free with credit
	logic [VC_W-1:0]   free_vc [NOUT];  // lowest such vc per output
	logic [NREQ-1:0]   req [NOUT];
	logic [NREQ-1:0]   grant [NOUT];
	logic [NOUT-1:0]   send;
	flit_t             send_flit [NOUT];       // winner with its downstream vc filled in
	logic [NUM_VC-1:0] take [NUM_LINKS];       // credit spent this cycle

	// vc allocation candidates per neighbour output
	always_comb
	begin
		for (int o = 0; o < NOUT; o++)
			free_vc[o] = '0;  // eject keeps vc 0
		for (int o = 0; o < NUM_LINKS; o++)
		begin
			free_any[o] = 1'b0;
			for (int d = NUM_VC - 1; d >= 0; d--)  // downward so lowest index sticks
				if (!dvc_busy[o][d] && (credit[o][d] != '0))
				begin
					free_any[o] = 1'b1;
					free_vc[o] = VC_W'(d);
				end
		end
	end

	// each input vc asks only the output on its route
	always_comb
	begin : b_req
		logic ok;
		for (int o = 0; o < NOUT; o++)
			req[o] = '0;
		for (int p = 0; p < NUM_LINKS; p++)
			for (int v = 0; v < NUM_VC; v++)
			begin
				if (!vc_ready[p][v])
					ok = 1'b0;
				else if (vc_route[p][v] == PORT_LOCAL)
					ok = !vc_needs_alloc[p][v] || !eject_lock;  // owner or free eject
				else if (vc_needs_alloc[p][v])
					ok = free_any[vc_route[p][v]];
				else
					ok = (credit[vc_route[p][v]][head_flit[p][v].body.vc] != '0);
				req[vc_route[p][v]][p * NUM_VC + v] = ok;
			end
	end

	genvar g;
	generate
		for (g = 0; g < NOUT; g++)
		begin : g_arb
			rr_arbiter #(.N(NREQ)) u_arb (
				.clk(clk),
				.reset(reset),
				.req(req[g]),
				.grant(grant[g])
			);
		end
	endgenerate

	// dequeue pulses, allocation answers and winner selection
	always_comb
	begin
		for (int p = 0; p < NUM_LINKS; p++)
			for (int v = 0; v < NUM_VC; v++)
			begin
				deq[p][v] = 1'b0;
				for (int o = 0; o < NOUT; o++)
					deq[p][v] = deq[p][v] | grant[o][p * NUM_VC + v];
				alloc_vc[p][v] = free_vc[vc_route[p][v]];  // latched only on a head
			end
		for (int o = 0; o < NOUT; o++)
		begin
			send[o] = |grant[o];
			send_flit[o] = '0;
			for (int p = 0; p < NUM_LINKS; p++)
				for (int v = 0; v < NUM_VC; v++)
					if (grant[o][p * NUM_VC + v])
					begin
						send_flit[o] = head_flit[p][v];
						if (vc_needs_alloc[p][v])
							send_flit[o].body.vc = free_vc[o];  // new packet gets a fresh vc
					end
		end
		for (int o = 0; o < NUM_LINKS; o++)
			for (int d = 0; d < NUM_VC; d++)
				take[o][d] = send[o] && (send_flit[o].body.vc == VC_W'(d));
	end

	// credits, vc ownership, eject lock and valids
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= '0;
			eject_valid <= 1'b0;
			eject_lock <= 1'b0;
			for (int o = 0; o < NUM_LINKS; o++)
			begin
				dvc_busy[o] <= '0;
				for (int d = 0; d < NUM_VC; d++)
					credit[o][d] <= CW'(BUFFER_DEPTH);
			end
		end
		else
		begin
			out_valid <= send[NUM_LINKS-1:0];
			eject_valid <= send[PORT_LOCAL];
			if (send[PORT_LOCAL] && (send_flit[PORT_LOCAL].head.kind == FLIT_HEAD))
				eject_lock <= 1'b1;
			else if (send[PORT_LOCAL] && (send_flit[PORT_LOCAL].head.kind == FLIT_TAIL))
				eject_lock <= 1'b0;
			for (int o = 0; o < NUM_LINKS; o++)
				for (int d = 0; d < NUM_VC; d++)
				begin
					credit[o][d] <= credit[o][d] - CW'(take[o][d]) + CW'(out_credit[o][d]);
					if (take[o][d] && (send_flit[o].head.kind == FLIT_HEAD))
						dvc_busy[o][d] <= 1'b1;
					else if (take[o][d] && (send_flit[o].head.kind == FLIT_TAIL))
						dvc_busy[o][d] <= 1'b0;  // single flits never set it
				end
		end
	end

	// output data registers load only when a flit goes out
	always_ff @(posedge clk)
	begin
		for (int o = 0; o < NUM_LINKS; o++)
			if (send[o])
				out_flit[o] <= send_flit[o];
		if (send[PORT_LOCAL])
			eject_flit <= send_flit[PORT_LOCAL];
	end

endmodule

// File: verilog/rr_arbiter.sv
// grant is combinational and one-hot, priority pointer only moves when some request wins
`timescale 1ns/10ps
module rr_arbiter #(
	parameter int N = 6
) (
	input  logic         clk,
	input  logic         reset,
	input  logic [N-1:0] req,
	output logic [N-1:0] grant
);
	localparam int PW = (N > 1) ? $clog2(N) : 1;

	logic [PW-1:0] ptr;      // requester with top priority this cycle
	logic [PW-1:0] win_idx;  // index of this cycle's winner
	logic          won;
	int            idx;

	// scan from ptr upward, wrapping around
	always_comb
	begin
		grant = '0;
		win_idx = ptr;
		won = 1'b0;
		for (int i = 0; i < N; i++)
		begin
			idx = (int'(ptr) + i) % N;
			if (!won && req[idx])
			begin
				grant[idx] = 1'b1;
				win_idx = PW'(idx);
				won = 1'b1;
			end
		end
	end

	// next search starts just past the winner
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (won)
			ptr <= (win_idx == PW'(N - 1)) ? '0 : win_idx + 1'b1;
	end

endmodule

// File: verilog/spidergon_node.sv
// link index equals port number (0 anticlockwise, 1 clockwise, 2 across); NODE_ID must be below NUM_NODES
`timescale 1ns/10ps
module spidergon_node
	import spidergon_pkg::*;
#(
	parameter int NODE_ID      = 0,
	parameter int BUFFER_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  flit_t                in_flit [NUM_LINKS],
	input  logic [NUM_LINKS-1:0] in_valid,
	output logic [NUM_VC-1:0]    in_credit [NUM_LINKS],  // one pulse per dequeued flit
	output flit_t                out_flit [NUM_LINKS],
	output logic [NUM_LINKS-1:0] out_valid,
	input  logic [NUM_VC-1:0]    out_credit [NUM_LINKS],  // returned by the neighbour
	output flit_t                eject_flit,
	output logic                 eject_valid
);
	// input ports to switch
	flit_t             head_flit [NUM_LINKS][NUM_VC];
	logic [NUM_VC-1:0] vc_ready [NUM_LINKS];
	logic [PORT_W-1:0] vc_route [NUM_LINKS][NUM_VC];
	logic [NUM_VC-1:0] vc_needs_alloc [NUM_LINKS];
	// switch back to input ports
	logic [NUM_VC-1:0] deq [NUM_LINKS];
	logic [VC_W-1:0]   alloc_vc [NUM_LINKS][NUM_VC];

	genvar i;
	generate
		for (i = 0; i < NUM_LINKS; i++)
		begin : g_in
			input_port #(
				.NODE_ID(NODE_ID),
				.BUFFER_DEPTH(BUFFER_DEPTH)
			) u_in (
				.clk(clk),
				.reset(reset),
				.in_flit(in_flit[i]),
				.in_valid(in_valid[i]),
				.in_credit(in_credit[i]),
				.head_flit(head_flit[i]),
				.vc_ready(vc_ready[i]),
				.vc_route(vc_route[i]),
				.vc_needs_alloc(vc_needs_alloc[i]),
				.deq(deq[i]),
				.alloc_vc(alloc_vc[i])
			);
		end
	endgenerate

	output_switch #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_switch (
		.clk(clk),
		.reset(reset),
		.head_flit(head_flit),
		.vc_ready(vc_ready),
		.vc_route(vc_route),
		.vc_needs_alloc(vc_needs_alloc),
		.deq(deq),
		.alloc_vc(alloc_vc),
		.out_flit(out_flit),
		.out_valid(out_valid),
		.out_credit(out_credit),
		.eject_flit(eject_flit),
		.eject_valid(eject_valid)
	);

endmodule

// File: verilog/spidergon_pkg.sv
// flit format for an 8-node ring with 2 VCs per link; NUM_NODES must stay a power of two divisible by 4
package spidergon_pkg;

	// network size
	localparam int NUM_NODES      = 8;  // nodes on the ring
	localparam int NODE_W         = 3;  // bits of a node number
	localparam int NUM_LINKS      = 3;  // neighbour links per node
	localparam int NUM_VC         = 2;  // virtual channels per link
	localparam int VC_W           = 1;  // bits of a vc number

	// flit word
	localparam int DATA_W         = 16;  // everything below type and vc
	localparam int FLIT_W         = 19;  // type 2 + vc 1 + data 16
	localparam int HEAD_PAYLOAD_W = 10;  // what is left after dest and src

	// output port numbers, shared by route results and link indices
	localparam int PORT_W = 2;
	localparam logic [PORT_W-1:0] PORT_ANTICLOCKWISE = 2'd0;
	localparam logic [PORT_W-1:0] PORT_CLOCKWISE     = 2'd1;
	localparam logic [PORT_W-1:0] PORT_ACROSS        = 2'd2;
	localparam logic [PORT_W-1:0] PORT_LOCAL         = 2'd3;  // stop here and eject

	// top two bits of every flit
	typedef enum logic [1:0] {
		FLIT_TAIL   = 2'b00,  // closes a packet
		FLIT_HEAD   = 2'b01,  // opens a packet, carries dest/src
		FLIT_BODY   = 2'b10,
		FLIT_SINGLE = 2'b11   // head and tail in one flit
	} flit_kind_t;

	// head view: routing info plus a short payload
	typedef struct packed {
		flit_kind_t                kind;
		logic [VC_W-1:0]           vc;       // input vc at the receiving node
		logic [NODE_W-1:0]         dest;
		logic [NODE_W-1:0]         src;
		logic [HEAD_PAYLOAD_W-1:0] payload;
	} head_fields_t;

	// body/tail view: the whole data field is payload
	typedef struct packed {
		flit_kind_t        kind;
		logic [VC_W-1:0]   vc;
		logic [DATA_W-1:0] payload;
	} body_fields_t;

	// kind and vc line up in both views, so either view reads them
	typedef union packed {
		head_fields_t head;
		body_fields_t body;
	} flit_t;

endpackage

// File: verilog/vc_fifo.sv
// no full flag, upstream credits must keep writes within DEPTH entries
`timescale 1ns/10ps
module vc_fifo
	import spidergon_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  wr_en,
	input  flit_t wr_flit,
	input  logic  rd_en,
	output flit_t rd_flit,
	output logic  empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	flit_t         mem [DEPTH];  // flit storage
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;        // entries held

	// wraps at DEPTH so non power of two depths work too
	function automatic logic [AW-1:0] wrap_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wrap_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= wrap_inc(rd_ptr);
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	assign rd_flit = mem[rd_ptr];  // head of queue, valid unless empty
	assign empty = (count == '0);

endmodule

// File: verilog/vc_reservation_table.sv
// one row per input vc; a row is written only on a multi-flit head and freed by its tail
`timescale 1ns/10ps
module vc_reservation_table
	import spidergon_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [NUM_VC-1:0] reserve,     // head of a multi-flit packet leaves
	input  logic [NUM_VC-1:0] release_en,  // tail leaves
	input  logic [PORT_W-1:0] new_route [NUM_VC],
	input  logic [VC_W-1:0]   new_vc [NUM_VC],
	output logic [NUM_VC-1:0] busy,
	output logic [PORT_W-1:0] route [NUM_VC],
	output logic [VC_W-1:0]   down_vc [NUM_VC]
);

	// busy flag per row
	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= '0;
		else
		begin
			for (int v = 0; v < NUM_VC; v++)
			begin
				if (reserve[v])
					busy[v] <= 1'b1;  // packet now owns its route
				else if (release_en[v])
					busy[v] <= 1'b0;
			end
		end
	end

	// locked output and downstream vc, only meaningful while busy
	always_ff @(posedge clk)
	begin
		for (int v = 0; v < NUM_VC; v++)
		begin
			if (reserve[v])
			begin
				route[v] <= new_route[v];
				down_vc[v] <= new_vc[v];  // vc granted by the switch this cycle
			end
		end
	end

	// a single-flit packet raises neither reserve nor release,
	// so its row simply stays free
	// reserve and release never hit the same row together:
	// a row is reserved only while free and released only while busy

endmodule
